// File: Bender.yml
package:
  name: dcache_axi_bridge

sources:
  - files:
      - source/axi_pkg.sv
      - source/line_pkg.sv
      - source/bridge_ctrl.sv
      - source/line_writer.sv
      - source/line_refill.sv
      - source/dcache_axi_bridge.sv
  - target: test
    files:
      - dv/dcache_axi_bridge_assertions.sv
      - dv/tb_dcache_axi_bridge.sv

// File: dcache_axi_bridge.f
source/axi_pkg.sv
source/line_pkg.sv
source/bridge_ctrl.sv
source/line_writer.sv
source/line_refill.sv
source/dcache_axi_bridge.sv
dv/dcache_axi_bridge_assertions.sv
dv/tb_dcache_axi_bridge.sv

// File: dv/dcache_axi_bridge_assertions.sv
`timescale 1ns/10ps

module dcache_axi_bridge_assertions (
    input logic clock,
    input logic reset,
    input logic aw_valid_o,
    input logic aw_ready_i,
    input logic w_valid_o,
    input logic w_ready_i,
    input logic w_last_o,
    input logic ar_valid_o,
    input logic ar_ready_i,
    input logic wb_done_o,
    input logic rf_done_o
);

    logic [1:0] w_beat_q;   // w handshakes in the current burst
    int         fail_cnt = 0;

    always_ff @(posedge clock or negedge reset) begin
        if (!reset) begin
            w_beat_q <= '0;
        end else if (w_valid_o && w_ready_i) begin
            w_beat_q <= w_beat_q + 1'b1;
        end
    end

    aw_hold: assert property (@(posedge clock) disable iff (!reset)
        aw_valid_o && !aw_ready_i |=> aw_valid_o)
        else begin
            $error("aw_valid_o dropped before aw_ready_i");
            fail_cnt++;
        end

    w_hold: assert property (@(posedge clock) disable iff (!reset)
        w_valid_o && !w_ready_i |=> w_valid_o)
        else begin
            $error("w_valid_o dropped before w_ready_i");
            fail_cnt++;
        end

    ar_hold: assert property (@(posedge clock) disable iff (!reset)
        ar_valid_o && !ar_ready_i |=> ar_valid_o)
        else begin
            $error("ar_valid_o dropped before ar_ready_i");
            fail_cnt++;
        end

    // last flag only on the fourth beat
    w_last_beat: assert property (@(posedge clock) disable iff (!reset)
        w_valid_o |-> (w_last_o == (w_beat_q == 2'd3)))
        else begin
            $error("w_last_o does not match the beat count");
            fail_cnt++;
        end

    wb_done_pulse: assert property (@(posedge clock) disable iff (!reset)
        wb_done_o |=> !wb_done_o)
        else begin
            $error("wb_done_o longer than one cycle");
            fail_cnt++;
        end

    rf_done_pulse: assert property (@(posedge clock) disable iff (!reset)
        rf_done_o |=> !rf_done_o)
        else begin
            $error("rf_done_o longer than one cycle");
            fail_cnt++;
        end

    quiet_after_reset: assert property (@(posedge clock)
        $rose(reset) |-> !(aw_valid_o || w_valid_o || ar_valid_o || wb_done_o || rf_done_o))
        else begin
            $error("valid or done output high right after reset");
            fail_cnt++;
        end

endmodule

bind dcache_axi_bridge dcache_axi_bridge_assertions u_assertions (
    .clock      (clock),
    .reset      (reset),
    .aw_valid_o (aw_valid_o),
    .aw_ready_i (aw_ready_i),
    .w_valid_o  (w_valid_o),
    .w_ready_i  (w_ready_i),
    .w_last_o   (w_last_o),
    .ar_valid_o (ar_valid_o),
    .ar_ready_i (ar_ready_i),
    .wb_done_o  (wb_done_o),
    .rf_done_o  (rf_done_o)
);

// File: dv/tb_dcache_axi_bridge.sv
`timescale 1ns/10ps

module tb_dcache_axi_bridge;
    import axi_pkg::*;
    import line_pkg::*;

    localparam int mem_bytes  = 1024;
    localparam int wait_limit = 300;   // cycles allowed per wait

    logic                    clock;
    logic                    reset;
    logic                    wb_valid_i, wb_ready_o, wb_done_o, wb_err_o;
    logic [addr_width-1:0]   wb_addr_i;
    cache_line_u             wb_line_i;
    logic [line_bytes-1:0]   wb_mask_i;
    logic                    rf_valid_i, rf_ready_o, rf_done_o, rf_err_o;
    logic [addr_width-1:0]   rf_addr_i;
    cache_line_u             rf_line_o;
    logic                    aw_valid_o, aw_ready_i, ar_valid_o, ar_ready_i;
    logic [addr_width-1:0]   aw_addr_o, ar_addr_o;
    logic                    w_valid_o, w_ready_i, w_last_o;
    logic [beat_bytes*8-1:0] w_data_o, r_data_i;
    logic [beat_bytes-1:0]   w_strb_o;
    logic                    b_valid_i, b_ready_o, r_valid_i, r_ready_o, r_last_i;
    logic [1:0]              b_resp_i, r_resp_i;

    // memory slave state
    logic [7:0]              mem [mem_bytes];
    logic                    err_line [mem_bytes/line_bytes];
    logic                    rand_delay;
    logic [15:0]             delay_lfsr;
    logic [15:0]             stim_lfsr;
    logic [addr_width-1:0]   wr_addr, rd_addr, last_aw_addr, last_ar_addr;
    int                      wr_beat, rd_beat;
    logic                    wr_resp_due, rd_active;
    logic [beat_bytes-1:0]   seen_strb [line_beats];

    cache_line_u             exp_rf_line;
    logic                    exp_rf_err, exp_wb_err;
    int                      rf_done_cnt, wb_done_cnt;
    int                      errors, tests_run, tests_failed;
    int                      assert_seen;   // assertion failures already counted

    dcache_axi_bridge UUT (.*);

    // 16-bit Fibonacci LFSR, taps 16 14 13 11
    function automatic logic [15:0] lfsr_step(logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    function automatic logic take_delay_bit();
        delay_lfsr = lfsr_step(delay_lfsr);
        return delay_lfsr[0];
    endfunction

    function automatic logic [63:0] take_stim_bits(int n);
        logic [63:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            stim_lfsr = lfsr_step(stim_lfsr);
            v[i] = stim_lfsr[0];
        end
        return v;
    endfunction

    function automatic cache_line_u random_line();
        cache_line_u l;
        for (int i = 0; i < line_beats; i++) begin
            l.beats[i] = take_stim_bits(64);
        end
        return l;
    endfunction

    // byte pattern over all ten address bits
    function automatic logic [7:0] fill_byte(int a);
        return 8'((a * 37) ^ (a >> 8) ^ 8'hc3);
    endfunction

    function automatic logic [beat_bytes*8-1:0] read_beat(logic [addr_width-1:0] addr, int beat);
        logic [beat_bytes*8-1:0] d;
        for (int i = 0; i < beat_bytes; i++) begin
            d[i*8 +: 8] = mem[(int'(addr[9:0]) + beat * beat_bytes + i) % mem_bytes];
        end
        return d;
    endfunction

    function automatic cache_line_u ref_line(logic [addr_width-1:0] addr);
        cache_line_u l;
        int base;
        base = int'({addr[9:offset_bits], 5'b0});
        for (int i = 0; i < line_bytes; i++) begin
            l.bytes[i] = mem[base + i];
        end
        return l;
    endfunction

    function automatic cache_line_u ref_merge(cache_line_u old_line, cache_line_u new_line,
                                              logic [line_bytes-1:0] mask);
        cache_line_u m;
        for (int i = 0; i < line_bytes; i++) begin
            m.bytes[i] = mask[i] ? new_line.bytes[i] : old_line.bytes[i];
        end
        return m;
    endfunction

    initial begin
        clock = 1'b0;
        forever #5 clock = ~clock;
    end

    // slave decides handshakes mid-cycle and drives 1 ns after the edge
    initial begin : slave_model
        logic b_hold;
        logic r_hold;
        aw_ready_i = 1'b0;
        w_ready_i  = 1'b0;
        ar_ready_i = 1'b0;
        b_valid_i  = 1'b0;
        b_resp_i   = resp_okay;
        r_valid_i  = 1'b0;
        r_last_i   = 1'b0;
        r_resp_i   = resp_okay;
        r_data_i   = '0;
        wr_addr = '0;
        rd_addr = '0;
        wr_beat = 0;
        rd_beat = 0;
        wr_resp_due = 1'b0;
        rd_active = 1'b0;
        forever begin
            @(negedge clock);
            b_hold = b_valid_i && !b_ready_o;
            r_hold = r_valid_i && !r_ready_o;
            if (aw_valid_o && aw_ready_i) begin
                wr_addr = aw_addr_o;
                last_aw_addr = aw_addr_o;
                wr_beat = 0;
            end
            if (w_valid_o && w_ready_i && wr_beat < line_beats) begin
                if (w_last_o != (wr_beat == line_beats - 1)) begin
                    $display("Fail w_last_o beat %0d: got %h expected %h", wr_beat, w_last_o,
                             wr_beat == line_beats - 1);
                    errors++;
                end
                for (int i = 0; i < beat_bytes; i++) begin
                    if (w_strb_o[i])
                        mem[(int'(wr_addr[9:0]) + wr_beat * beat_bytes + i) % mem_bytes] =
                            w_data_o[i*8 +: 8];
                end
                seen_strb[wr_beat] = w_strb_o;
                wr_beat++;
                if (w_last_o) wr_resp_due = 1'b1;
            end
            if (b_valid_i && b_ready_o) wr_resp_due = 1'b0;
            if (ar_valid_o && ar_ready_i) begin
                rd_addr = ar_addr_o;
                last_ar_addr = ar_addr_o;
                rd_beat = 0;
                rd_active = 1'b1;
            end
            if (r_valid_i && r_ready_o) begin
                rd_beat++;
                if (rd_beat == line_beats) rd_active = 1'b0;
            end
            @(posedge clock);
            #1;
            aw_ready_i = !rand_delay || take_delay_bit();
            w_ready_i  = !rand_delay || take_delay_bit();
            ar_ready_i = !rand_delay || take_delay_bit();
            b_valid_i  = wr_resp_due && (b_hold || !rand_delay || take_delay_bit());
            b_resp_i   = err_line[wr_addr[9:offset_bits]] ? resp_slverr : resp_okay;
            r_valid_i  = rd_active && (r_hold || !rand_delay || take_delay_bit());
            r_last_i   = (rd_beat == line_beats - 1);
            r_resp_i   = err_line[rd_addr[9:offset_bits]] ? resp_slverr : resp_okay;
            r_data_i   = read_beat(rd_addr, rd_beat);
        end
    end

    // compares every done pulse with what the running test expects
    initial begin
        forever begin
            @(negedge clock);
            if (rf_done_o) begin
                rf_done_cnt++;
                if (rf_line_o !== exp_rf_line) begin
                    $display("Fail rf_line_o: got %h expected %h", rf_line_o, exp_rf_line);
                    errors++;
                end
                if (rf_err_o !== exp_rf_err) begin
                    $display("Fail rf_err_o: got %h expected %h", rf_err_o, exp_rf_err);
                    errors++;
                end
            end
            if (wb_done_o) begin
                wb_done_cnt++;
                if (wb_err_o !== exp_wb_err) begin
                    $display("Fail wb_err_o: got %h expected %h", wb_err_o, exp_wb_err);
                    errors++;
                end
            end
        end
    end

    task automatic timeout_abort(string what);
        $display("timeout while waiting for %s", what);
        $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed + 1, errors);
        $display(">>> FAIL");
        $finish;
    endtask

    task automatic issue_refill(logic [addr_width-1:0] addr);
        int n;
        n = 0;
        @(posedge clock);
        #1;
        rf_valid_i = 1'b1;
        rf_addr_i  = addr;
        @(negedge clock);
        while (!rf_ready_o) begin
            if (n == wait_limit) timeout_abort("rf_ready_o");
            else begin
                n++;
                @(negedge clock);
            end
        end
        @(posedge clock);   // accepted here
        #1;
        rf_valid_i = 1'b0;
    endtask

    task automatic issue_writeback(logic [addr_width-1:0] addr, cache_line_u line,
                                   logic [line_bytes-1:0] mask);
        int n;
        n = 0;
        @(posedge clock);
        #1;
        wb_valid_i = 1'b1;
        wb_addr_i  = addr;
        wb_line_i  = line;
        wb_mask_i  = mask;
        @(negedge clock);
        while (!wb_ready_o) begin
            if (n == wait_limit) timeout_abort("wb_ready_o");
            else begin
                n++;
                @(negedge clock);
            end
        end
        @(posedge clock);
        #1;
        wb_valid_i = 1'b0;
    endtask

    task automatic wait_rf_done(int start);
        int n;
        n = 0;
        while (rf_done_cnt == start) begin
            if (n == wait_limit) timeout_abort("rf_done_o");
            else begin
                n++;
                @(posedge clock);
            end
        end
    endtask

    task automatic wait_wb_done(int start);
        int n;
        n = 0;
        while (wb_done_cnt == start) begin
            if (n == wait_limit) timeout_abort("wb_done_o");
            else begin
                n++;
                @(posedge clock);
            end
        end
    endtask

    task automatic refill_check(logic [addr_width-1:0] addr, cache_line_u exp_line);
        int start;
        start = rf_done_cnt;
        exp_rf_line = exp_line;
        exp_rf_err  = err_line[addr[9:offset_bits]];
        issue_refill(addr);
        wait_rf_done(start);
    endtask

    task automatic writeback(logic [addr_width-1:0] addr, cache_line_u line,
                             logic [line_bytes-1:0] mask);
        int start;
        start = wb_done_cnt;
        exp_wb_err = err_line[addr[9:offset_bits]];
        issue_writeback(addr, line, mask);
        wait_wb_done(start);
    endtask

    task automatic end_test(string name, int mark);
        tests_run++;
        errors += UUT.u_assertions.fail_cnt - assert_seen;   // concurrent checks in this test
        assert_seen = UUT.u_assertions.fail_cnt;
        if (errors == mark) begin
            $display("test %0d %s: ok", tests_run, name);
        end else begin
            tests_failed++;
            $display("test %0d %s: failed with %0d errors", tests_run, name, errors - mark);
        end
    endtask

    initial begin
        cache_line_u           old_line;
        cache_line_u           new_line;
        logic [line_bytes-1:0] mask;
        logic [addr_width-1:0] wb_a;
        logic [addr_width-1:0] rf_a;
        int                    mark;
        int                    wb_start;
        int                    rf_start;
        reset = 1'b0;
        wb_valid_i = 1'b0;
        wb_addr_i  = '0;
        wb_line_i  = '0;
        wb_mask_i  = '0;
        rf_valid_i = 1'b0;
        rf_addr_i  = '0;
        rand_delay = 1'b0;
        delay_lfsr = 16'd20;
        stim_lfsr  = 16'd20;
        errors = 0;
        tests_run = 0;
        tests_failed = 0;
        assert_seen = 0;
        rf_done_cnt = 0;
        wb_done_cnt = 0;
        for (int a = 0; a < mem_bytes; a++) begin
            mem[a] = fill_byte(a);
        end
        for (int i = 0; i < mem_bytes / line_bytes; i++) begin
            err_line[i] = (i == 3) || (i == 24);   // lines 0x60 and 0x300 answer slverr
        end
        repeat (3) @(posedge clock);
        #1;
        reset = 1'b1;

        mark = errors;
        @(negedge clock);
        if ({wb_ready_o, rf_ready_o} !== 2'b11) begin
            $display("Fail {wb_ready_o, rf_ready_o}: got %h expected %h",
                     {wb_ready_o, rf_ready_o}, 2'b11);
            errors++;
        end
        if ({aw_valid_o, w_valid_o, ar_valid_o, b_ready_o, r_ready_o} !== 5'b0) begin
            $display("Fail %s: got %h expected %h",
                     "{aw_valid_o, w_valid_o, ar_valid_o, b_ready_o, r_ready_o}",
                     {aw_valid_o, w_valid_o, ar_valid_o, b_ready_o, r_ready_o}, 5'b0);
            errors++;
        end
        refill_check(32'h40, ref_line(32'h40));
        end_test("reset and refill", mark);

        mark = errors;
        new_line = random_line();
        writeback(32'h80, new_line, '1);
        refill_check(32'h80, new_line);
        end_test("full write-back", mark);

        mark = errors;
        old_line = ref_line(32'hc0);
        new_line = random_line();
        mask = line_bytes'(take_stim_bits(line_bytes));
        writeback(32'hc0, new_line, mask);
        for (int b = 0; b < line_beats; b++) begin
            if (seen_strb[b] !== mask[b*beat_bytes +: beat_bytes]) begin
                $display("Fail w_strb_o beat %0d: got %h expected %h", b, seen_strb[b],
                         mask[b*beat_bytes +: beat_bytes]);
                errors++;
            end
        end
        refill_check(32'hc0, ref_merge(old_line, new_line, mask));
        end_test("partial write-back", mark);

        mark = errors;
        new_line = random_line();
        writeback(32'h10b, new_line, '1);
        if (last_aw_addr !== 32'h100) begin
            $display("Fail aw_addr_o: got %h expected %h", last_aw_addr, 32'h100);
            errors++;
        end
        refill_check(32'h11d, new_line);
        if (last_ar_addr !== 32'h100) begin
            $display("Fail ar_addr_o: got %h expected %h", last_ar_addr, 32'h100);
            errors++;
        end
        end_test("unaligned address", mark);

        mark = errors;
        rand_delay = 1'b1;
        wb_start = wb_done_cnt;
        rf_start = rf_done_cnt;
        for (int k = 0; k < 6; k++) begin
            wb_a = 32'h200 + k * line_bytes;
            rf_a = 32'h340 + k * line_bytes;
            old_line = ref_line(wb_a);
            new_line = random_line();
            mask = line_bytes'(take_stim_bits(line_bytes));
            exp_rf_line = ref_line(rf_a);
            exp_rf_err  = err_line[rf_a[9:offset_bits]];
            exp_wb_err  = err_line[wb_a[9:offset_bits]];
            fork
                issue_writeback(wb_a, new_line, mask);
                issue_refill(rf_a);
            join
            wait_wb_done(wb_start + k);
            wait_rf_done(rf_start + 2 * k);
            refill_check(wb_a, ref_merge(old_line, new_line, mask));
        end
        repeat (10) @(posedge clock);
        if (wb_done_cnt != wb_start + 6 || rf_done_cnt != rf_start + 12) begin
            $display("done pulse count does not match the number of requests");
            errors++;
        end
        end_test("overlapped transfers with random delays", mark);

        mark = errors;
        rand_delay = 1'b0;
        refill_check(32'h60, ref_line(32'h60));
        new_line = random_line();
        writeback(32'h300, new_line, '1);
        refill_check(32'h300, new_line);
        writeback(32'h20, random_line(), '1);
        refill_check(32'h40, ref_line(32'h40));
        end_test("error responses", mark);

        $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
        if (errors == 0)
            $display(">>> PASS");
        else
            $display(">>> FAIL");
        $finish;
    end

endmodule

// File: source/axi_pkg.sv
package axi_pkg;

    // address and data geometry of the memory port
    localparam int addr_width = 32;
    localparam int beat_bytes = 8;   // 64-bit data bus

    // response codes, upper bit set means error
    localparam logic [1:0] resp_okay   = 2'b00;
    localparam logic [1:0] resp_slverr = 2'b10;

    // channel phases, shared by the write and read sequencers
    localparam logic [1:0] ph_idle = 2'b00;   // ready for a new request
    localparam logic [1:0] ph_addr = 2'b01;   // aw / ar valid
    localparam logic [1:0] ph_data = 2'b11;   // w / r beats
    localparam logic [1:0] ph_resp = 2'b10;   // b wait on write, done cycle on read

endpackage

// File: source/bridge_ctrl.sv
`timescale 1ns/10ps

module bridge_ctrl (
    input  logic clock,
    input  logic reset,
    // cache side requests
    input  logic wb_valid_i,
    input  logic rf_valid_i,
    output logic wb_ready_o,
    output logic rf_ready_o,
    output logic wb_done_o,
    // axi handshakes
    input  logic aw_ready_i,
    input  logic w_ready_i,
    input  logic b_valid_i,
    input  logic ar_ready_i,
    input  logic r_valid_i,
    input  logic r_last_i,
    output logic aw_valid_o,
    output logic w_valid_o,
    output logic b_ready_o,
    output logic ar_valid_o,
    output logic r_ready_o,
    // datapath strobes
    input  logic beat_last_i,
    output logic wb_capture_o,
    output logic rf_capture_o,
    output logic w_beat_fire_o,
    output logic r_beat_fire_o,
    output logic rf_finish_o
);
    import axi_pkg::*;

    logic [1:0] w_state_q;
    logic [1:0] w_state_d;
    logic [1:0] r_state_q;
    logic [1:0] r_state_d;
    logic       wb_done_q;

    always_ff @(posedge clock or negedge reset) begin
        if (!reset) begin
            w_state_q <= ph_idle;
            r_state_q <= ph_idle;
            wb_done_q <= 1'b0;
        end else begin
            w_state_q <= w_state_d;
            r_state_q <= r_state_d;
            wb_done_q <= b_valid_i & b_ready_o;   // one cycle after the b handshake
        end
    end

    // write-back: aw, then four w beats, then b
    always_comb begin
        w_state_d = w_state_q;
        case (w_state_q)
            ph_idle: if (wb_capture_o) w_state_d = ph_addr;
            ph_addr: if (aw_ready_i) w_state_d = ph_data;
            ph_data: if (w_beat_fire_o && beat_last_i) w_state_d = ph_resp;
            ph_resp: if (b_valid_i) w_state_d = ph_idle;
        endcase
    end

    // refill: ar, r beats until last, then one done cycle
    always_comb begin
        r_state_d = r_state_q;
        case (r_state_q)
            ph_idle: if (rf_capture_o) r_state_d = ph_addr;
            ph_addr: if (ar_ready_i) r_state_d = ph_data;
            ph_data: if (rf_finish_o) r_state_d = ph_resp;
            ph_resp: r_state_d = ph_idle;   // rf_done_o is out this cycle
        endcase
    end

    assign wb_ready_o = (w_state_q == ph_idle);
    assign aw_valid_o = (w_state_q == ph_addr);
    assign w_valid_o  = (w_state_q == ph_data);
    assign b_ready_o  = (w_state_q == ph_resp);

    assign rf_ready_o = (r_state_q == ph_idle);
    assign ar_valid_o = (r_state_q == ph_addr);
    assign r_ready_o  = (r_state_q == ph_data);

    assign wb_capture_o  = wb_valid_i & wb_ready_o;
    assign rf_capture_o  = rf_valid_i & rf_ready_o;
    assign w_beat_fire_o = w_valid_o & w_ready_i;
    assign r_beat_fire_o = r_valid_i & r_ready_o;
    assign rf_finish_o   = r_beat_fire_o & r_last_i;   // burst end is taken from the slave

    assign wb_done_o = wb_done_q;

endmodule

// File: source/dcache_axi_bridge.sv
`timescale 1ns/10ps

module dcache_axi_bridge (
    input  logic                                clock,
    input  logic                                reset,
    // cache write-back channel
    input  logic                                wb_valid_i,
    output logic                                wb_ready_o,
    input  logic [axi_pkg::addr_width-1:0]      wb_addr_i,
    input  line_pkg::cache_line_u               wb_line_i,
    input  logic [line_pkg::line_bytes-1:0]     wb_mask_i,
    output logic                                wb_done_o,
    output logic                                wb_err_o,
    // cache refill channel
    input  logic                                rf_valid_i,
    output logic                                rf_ready_o,
    input  logic [axi_pkg::addr_width-1:0]      rf_addr_i,
    output logic                                rf_done_o,
    output line_pkg::cache_line_u               rf_line_o,
    output logic                                rf_err_o,
    // axi write address
    output logic                                aw_valid_o,
    input  logic                                aw_ready_i,
    output logic [axi_pkg::addr_width-1:0]      aw_addr_o,
    // axi write data
    output logic                                w_valid_o,
    input  logic                                w_ready_i,
    output logic [axi_pkg::beat_bytes*8-1:0]    w_data_o,
    output logic [axi_pkg::beat_bytes-1:0]      w_strb_o,
    output logic                                w_last_o,
    // axi write response
    input  logic                                b_valid_i,
    output logic                                b_ready_o,
    input  logic [1:0]                          b_resp_i,
    // axi read address
    output logic                                ar_valid_o,
    input  logic                                ar_ready_i,
    output logic [axi_pkg::addr_width-1:0]      ar_addr_o,
    // axi read data
    input  logic                                r_valid_i,
    output logic                                r_ready_o,
    input  logic [axi_pkg::beat_bytes*8-1:0]    r_data_i,
    input  logic [1:0]                          r_resp_i,
    input  logic                                r_last_i
);

    logic wb_capture;
    logic rf_capture;
    logic w_beat_fire;
    logic r_beat_fire;
    logic rf_finish;
    logic beat_last;
    logic b_fire;

    assign b_fire = b_valid_i & b_ready_o;

    bridge_ctrl u_ctrl (
        .clock         (clock),
        .reset         (reset),
        .wb_valid_i    (wb_valid_i),
        .rf_valid_i    (rf_valid_i),
        .wb_ready_o    (wb_ready_o),
        .rf_ready_o    (rf_ready_o),
        .wb_done_o     (wb_done_o),
        .aw_ready_i    (aw_ready_i),
        .w_ready_i     (w_ready_i),
        .b_valid_i     (b_valid_i),
        .ar_ready_i    (ar_ready_i),
        .r_valid_i     (r_valid_i),
        .r_last_i      (r_last_i),
        .aw_valid_o    (aw_valid_o),
        .w_valid_o     (w_valid_o),
        .b_ready_o     (b_ready_o),
        .ar_valid_o    (ar_valid_o),
        .r_ready_o     (r_ready_o),
        .beat_last_i   (beat_last),
        .wb_capture_o  (wb_capture),
        .rf_capture_o  (rf_capture),
        .w_beat_fire_o (w_beat_fire),
        .r_beat_fire_o (r_beat_fire),
        .rf_finish_o   (rf_finish)
    );

    // write-back payload and beat slicing
    line_writer u_writer (
        .clock         (clock),
        .reset         (reset),
        .wb_capture_i  (wb_capture),
        .w_beat_fire_i (w_beat_fire),
        .wb_addr_i     (wb_addr_i),
        .wb_line_i     (wb_line_i),
        .wb_mask_i     (wb_mask_i),
        .aw_addr_o     (aw_addr_o),
        .w_data_o      (w_data_o),
        .w_strb_o      (w_strb_o),
        .w_last_o      (w_last_o),
        .beat_last_o   (beat_last)
    );

    // refill assembly plus both response decodes
    line_refill u_refill (
        .clock         (clock),
        .reset         (reset),
        .rf_capture_i  (rf_capture),
        .r_beat_fire_i (r_beat_fire),
        .rf_finish_i   (rf_finish),
        .rf_addr_i     (rf_addr_i),
        .r_data_i      (r_data_i),
        .r_resp_i      (r_resp_i),
        .b_resp_i      (b_resp_i),
        .b_fire_i      (b_fire),
        .ar_addr_o     (ar_addr_o),
        .rf_line_o     (rf_line_o),
        .rf_err_o      (rf_err_o),
        .rf_done_o     (rf_done_o),
        .wb_err_o      (wb_err_o)
    );

endmodule

// File: source/line_pkg.sv
package line_pkg;

    // one cache line is a fixed four-beat INCR burst
    localparam int line_beats  = 4;
    localparam int line_bytes  = line_beats * axi_pkg::beat_bytes;   // 32
    localparam int offset_bits = $clog2(line_bytes);                 // 5

    typedef logic [$clog2(line_beats)-1:0] beat_idx_t;

    // same 256 bits, seen as bus beats or as single bytes
    typedef union packed {
        logic [line_beats-1:0][axi_pkg::beat_bytes*8-1:0] beats;  // beat 0 in the low bits
        logic [line_bytes-1:0][7:0]                       bytes;  // byte i pairs with mask bit i
    } cache_line_u;

endpackage

// File: source/line_refill.sv
`timescale 1ns/10ps

module line_refill (
    input  logic                                clock,
    input  logic                                reset,
    input  logic                                rf_capture_i,
    input  logic                                r_beat_fire_i,
    input  logic                                rf_finish_i,
    input  logic [axi_pkg::addr_width-1:0]      rf_addr_i,
    input  logic [axi_pkg::beat_bytes*8-1:0]    r_data_i,
    input  logic [1:0]                          r_resp_i,
    input  logic [1:0]                          b_resp_i,
    input  logic                                b_fire_i,
    output logic [axi_pkg::addr_width-1:0]      ar_addr_o,
    output line_pkg::cache_line_u               rf_line_o,
    output logic                                rf_err_o,
    output logic                                rf_done_o,
    output logic                                wb_err_o
);
    import axi_pkg::*;
    import line_pkg::*;

    logic [addr_width-1:0] addr_q;
    cache_line_u           line_q;
    beat_idx_t             beat_q;     // slot for the next r beat
    logic                  r_err_q;    // sticky over the burst
    logic                  rf_err_q;
    logic                  rf_done_q;
    logic                  wb_err_q;

    always_ff @(posedge clock) begin
        if (rf_capture_i) begin
            addr_q <= {rf_addr_i[addr_width-1:offset_bits], {offset_bits{1'b0}}};
        end
        if (r_beat_fire_i) begin
            line_q.beats[beat_q] <= r_data_i;
        end
    end

    always_ff @(posedge clock or negedge reset) begin
        if (!reset) begin
            beat_q    <= '0;
            r_err_q   <= 1'b0;
            rf_err_q  <= 1'b0;
            rf_done_q <= 1'b0;
            wb_err_q  <= 1'b0;
        end else begin
            rf_done_q <= rf_finish_i;
            if (rf_capture_i) begin
                beat_q  <= '0;
                r_err_q <= 1'b0;
            end else if (r_beat_fire_i) begin
                beat_q  <= beat_q + 1'b1;
                r_err_q <= r_err_q | r_resp_i[1];
            end
            // include the last beat's own response
            if (rf_finish_i) rf_err_q <= r_err_q | r_resp_i[1];
            if (b_fire_i) wb_err_q <= b_resp_i[1];   // lines up with wb_done_o
        end
    end

    assign ar_addr_o = addr_q;
    assign rf_line_o = line_q;
    assign rf_err_o  = rf_err_q;
    assign rf_done_o = rf_done_q;
    assign wb_err_o  = wb_err_q;

endmodule

// File: source/line_writer.sv
`timescale 1ns/10ps

module line_writer (
    input  logic                                clock,
    input  logic                                reset,
    input  logic                                wb_capture_i,
    input  logic                                w_beat_fire_i,
    input  logic [axi_pkg::addr_width-1:0]      wb_addr_i,
    input  line_pkg::cache_line_u               wb_line_i,
    input  logic [line_pkg::line_bytes-1:0]     wb_mask_i,
    output logic [axi_pkg::addr_width-1:0]      aw_addr_o,
    output logic [axi_pkg::beat_bytes*8-1:0]    w_data_o,
    output logic [axi_pkg::beat_bytes-1:0]      w_strb_o,
    output logic                                w_last_o,
    output logic                                beat_last_o
);
    import axi_pkg::*;
    import line_pkg::*;

    logic [addr_width-1:0] addr_q;
    cache_line_u           line_q;
    logic [line_bytes-1:0] mask_q;
    beat_idx_t             beat_q;   // next beat to send
    logic                  at_last;

    // request payload, held for the whole burst
    always_ff @(posedge clock) begin
        if (wb_capture_i) begin
            addr_q <= {wb_addr_i[addr_width-1:offset_bits], {offset_bits{1'b0}}};
            line_q <= wb_line_i;
            mask_q <= wb_mask_i;
        end
    end

    always_ff @(posedge clock or negedge reset) begin
        if (!reset) begin
            beat_q <= '0;
        end else if (wb_capture_i) begin
            beat_q <= '0;
        end else if (w_beat_fire_i) begin
            beat_q <= beat_q + 1'b1;   // wraps back to 0 after the last beat
        end
    end

    assign at_last = (beat_q == beat_idx_t'(line_beats - 1));

    assign aw_addr_o   = addr_q;
    assign w_data_o    = line_q.beats[beat_q];
    assign w_strb_o    = mask_q[beat_q*beat_bytes +: beat_bytes];   // eight mask bits per beat
    assign w_last_o    = at_last;
    assign beat_last_o = at_last;

endmodule
